/* sim.f */
+incdir+.
dcache_pkg.sv
dcache_req_buffer.sv
dcache_tagv.sv
dcache_data.sv
dcache_ctrl.sv
dcache_mem_port.sv
dcache_top.sv
tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dcache -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile step returned $status"
    exit $status
fi

./obj_dir/Vtb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation run returned $status"
    exit $status
fi
exit 0

/* tb_dcache.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module tb_dcache;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 200;         // cycles per wait

    logic                    clk;
    logic                    rstn;
    logic                    req_valid;
    logic                    req_ready;
    dcache_pkg::dc_req_t     req;
    dcache_pkg::dc_resp_t    resp;
    logic                    mem_req;
    dcache_pkg::dc_mem_req_t mem_cmd;
    logic                    mem_addr_ok;
    logic                    mem_data_ok;
    dcache_pkg::dc_line_t    mem_rdata;

    logic [31:0]          mem_model  [MEM_WORDS];
    logic [31:0]          shadow_mem [MEM_WORDS];
    logic [`DC_TAG_W-1:0] sh_tag     [`DC_WAYS][`DC_SETS];
    logic                 sh_valid   [`DC_WAYS][`DC_SETS];
    logic                 sh_lru     [`DC_SETS];   // most recent way
    logic [31:0]          sh_data    [`DC_WAYS][`DC_SETS][`DC_WORDS];

    integer             seed = 32'hc843;
    int                 line_reads = 0;     // counted by the memory model
    int                 mem_reqs = 0;
    int                 n_issued = 0;
    int                 n_checked = 0;
    dcache_pkg::dc_op_e exp_op;
    logic [31:0]        exp_addr;
    logic [31:0]        exp_rdata;
    int                 exp_reads;
    int                 exp_reqs;
    int                 base_reads;
    int                 base_reqs;

    dcache_top dut (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_ready(req_ready),
        .req(req), .resp(resp), .mem_req(mem_req), .mem_cmd(mem_cmd),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  wstrb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                r[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return r;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////

    // expected load word and memory traffic with the shadow state updated on the way
    function automatic logic [31:0] predict_access(input dcache_pkg::dc_op_e op,
                                                   input logic        unc,
                                                   input logic [31:0] addr,
                                                   input logic [31:0] wdata,
                                                   input logic [3:0]  wstrb,
                                                   output int         reads,
                                                   output int         reqs);
        logic [`DC_TAG_W-1:0]    t;
        logic [`DC_INDEX_W-1:0]  s;
        logic [`DC_OFFSET_W-1:0] wd;
        logic [9:0]              widx;
        logic                    found;
        logic                    way;
        logic [31:0]             result;
        t      = addr[`DC_TAG_LSB +: `DC_TAG_W];
        s      = addr[`DC_INDEX_LSB +: `DC_INDEX_W];
        wd     = addr[`DC_WORD_LSB +: `DC_OFFSET_W];
        widx   = addr[11:2];
        found  = 1'b0;
        way    = 1'b0;
        result = '0;
        reads  = 0;
        reqs   = 1;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (sh_valid[w][s] && sh_tag[w][s] == t) begin
                found = 1'b1;
                way   = w[0];
            end
        end
        if (op == dcache_pkg::op_inval) begin
            reqs = 0;
            if (found) begin
                sh_valid[way][s] = 1'b0;
                sh_lru[s]        = ~way;    // freed way goes first
            end
        end else if (op == dcache_pkg::op_store) begin
            shadow_mem[widx] = merge_bytes(shadow_mem[widx], wdata, wstrb);
            if (!unc && found) begin
                sh_data[way][s][wd] = merge_bytes(sh_data[way][s][wd], wdata, wstrb);
            end
        end else if (unc) begin
            result = shadow_mem[widx];      // straight from memory
        end else if (found) begin
            reqs      = 0;
            sh_lru[s] = way;
            result    = sh_data[way][s][wd];  // may be stale
        end else begin
            reads = 1;
            if (sh_valid[0][s] == sh_valid[1][s]) begin
                way = ~sh_lru[s];
            end else begin
                way = sh_valid[0][s];       // the invalid one
            end
            for (int w = 0; w < `DC_WORDS; w++) begin
                sh_data[way][s][w] = shadow_mem[{widx[9:`DC_OFFSET_W], `DC_OFFSET_W'(w)}];
            end
            sh_tag[way][s]   = t;
            sh_valid[way][s] = 1'b1;
            sh_lru[s]        = way;
            result           = sh_data[way][s][wd];
        end
        return result;
    endfunction

    //////////////////////////////
    // memory model
    //////////////////////////////

    initial begin
        logic [31:0]             r;
        int                      addr_delay;
        int                      data_delay;
        dcache_pkg::dc_mem_req_t cmd;
        logic [9:0]              widx;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                r          = $random(seed);
                addr_delay = int'(r[1:0]);
                data_delay = 1 + int'(r[3:2]);
                cmd        = mem_cmd;
                for (int d = 0; d < addr_delay; d++) begin
                    @(negedge clk);
                    assert (mem_req && mem_cmd == cmd) else
                        abort_run("memory request dropped or changed before addr_ok");
                end
                widx        = cmd.addr[11:2];
                mem_addr_ok = 1'b1;
                mem_reqs    = mem_reqs + 1;
                if (cmd.line) begin
                    line_reads = line_reads + 1;
                    assert (cmd.addr[3:0] == 4'h0) else abort_run($sformatf(
                        "[ERROR] %0t ns: line read at unaligned address %h", $time, cmd.addr));
                end
                @(negedge clk);
                mem_addr_ok = 1'b0;
                repeat (data_delay - 1) @(negedge clk);
                mem_rdata = '0;
                if (cmd.wr) begin
                    mem_model[widx] = merge_bytes(mem_model[widx], cmd.wdata, cmd.wstrb);
                end else if (cmd.line) begin
                    for (int w = 0; w < `DC_WORDS; w++) begin
                        mem_rdata[w] = mem_model[{widx[9:`DC_OFFSET_W], `DC_OFFSET_W'(w)}];
                    end
                end else begin
                    mem_rdata[0] = mem_model[widx];     // single word in lane 0
                end
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

    //////////////////////////////
    // response checker
    //////////////////////////////

    always @(negedge clk) begin
        if (rstn && resp.valid) begin
            assert (n_issued == n_checked + 1) else
                abort_run("response seen with no request in flight");
            assert (!req_ready) else
                abort_run("req_ready was high in a response cycle");
            if (exp_op == dcache_pkg::op_load) begin
                assert (resp.rdata == exp_rdata) else abort_run($sformatf(
                    "[ERROR] %0t ns: load %h returned %h, expected %h",
                    $time, exp_addr, resp.rdata, exp_rdata));
            end
            assert (line_reads - base_reads == exp_reads) else abort_run($sformatf(
                "[ERROR] %0t ns: access %h made %0d line reads, expected %0d",
                $time, exp_addr, line_reads - base_reads, exp_reads));
            assert (mem_reqs - base_reqs == exp_reqs) else abort_run($sformatf(
                "[ERROR] %0t ns: access %h made %0d memory requests, expected %0d",
                $time, exp_addr, mem_reqs - base_reqs, exp_reqs));
            if (exp_op == dcache_pkg::op_store) begin
                assert (mem_model[exp_addr[11:2]] == shadow_mem[exp_addr[11:2]]) else
                    abort_run($sformatf("[ERROR] %0t ns: memory at %h holds %h, expected %h",
                        $time, exp_addr, mem_model[exp_addr[11:2]],
                        shadow_mem[exp_addr[11:2]]));
            end
            n_checked = n_checked + 1;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // want_reads below zero leaves the line read count to the reference
    task automatic run_access(input dcache_pkg::dc_op_e op, input logic unc,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, input int want_reads);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!req_ready) begin
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                abort_run("timeout: the cache never raised req_ready");
            end
            @(negedge clk);
        end
        exp_rdata = predict_access(op, unc, addr, wdata, wstrb, exp_reads, exp_reqs);
        if (want_reads >= 0) begin
            assert (exp_reads == want_reads) else abort_run($sformatf(
                "[ERROR] %0t ns: reference gives %0d line reads at %h, directed case wants %0d",
                $time, exp_reads, addr, want_reads));
        end
        exp_op       = op;
        exp_addr     = addr;
        base_reads   = line_reads;
        base_reqs    = mem_reqs;
        n_issued     = n_issued + 1;
        req.op       = op;
        req.uncached = unc;
        req.paddr    = addr;
        req.wdata    = wdata;
        req.wstrb    = wstrb;
        req_valid    = 1'b1;
        @(negedge clk);                     // accepted on the edge just passed
        req_valid = 1'b0;
        cycles    = 0;
        while (!resp.valid) begin
            assert (!req_ready) else
                abort_run("req_ready was high while a request was in flight");
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                abort_run("timeout: no response from the cache");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        logic [31:0]        r;
        logic [31:0]        addr;
        logic [31:0]        wdata;
        dcache_pkg::dc_op_e op;
        logic               unc;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i]  = (32'(i) * 32'h0001_0003) ^ 32'ha5c3_0000;
            shadow_mem[i] = mem_model[i];
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                sh_valid[w][s] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        assert (req_ready && !resp.valid && !mem_req) else
            abort_run("cache is not idle after reset");

        // miss then hits on one line
        run_access(dcache_pkg::op_load, 1'b0, 32'h040, '0, 4'h0, 1);
        run_access(dcache_pkg::op_load, 1'b0, 32'h048, '0, 4'h0, 0);
        run_access(dcache_pkg::op_load, 1'b0, 32'h040, '0, 4'h0, 0);

        // partial stores to a cached line and to an uncached line
        run_access(dcache_pkg::op_store, 1'b0, 32'h044, 32'haabb_ccdd, 4'b0101, 0);
        run_access(dcache_pkg::op_load, 1'b0, 32'h044, '0, 4'h0, 0);
        run_access(dcache_pkg::op_store, 1'b0, 32'h380, 32'h1122_3344, 4'b0010, 0);
        run_access(dcache_pkg::op_load, 1'b0, 32'h380, '0, 4'h0, 1);   // no allocate
        run_access(dcache_pkg::op_load, 1'b0, 32'h380, '0, 4'h0, 0);

        // LRU order in set 2 with A at 0x020 and B at 0x120 and C at 0x220
        run_access(dcache_pkg::op_load, 1'b0, 32'h020, '0, 4'h0, 1);
        run_access(dcache_pkg::op_load, 1'b0, 32'h120, '0, 4'h0, 1);
        run_access(dcache_pkg::op_load, 1'b0, 32'h020, '0, 4'h0, 0);
        run_access(dcache_pkg::op_load, 1'b0, 32'h220, '0, 4'h0, 1);
        run_access(dcache_pkg::op_load, 1'b0, 32'h020, '0, 4'h0, 0);   // A kept
        run_access(dcache_pkg::op_load, 1'b0, 32'h120, '0, 4'h0, 1);   // B was evicted

        // memory changed behind the cache
        mem_model[32'h040 >> 2]  = 32'h1357_9bdf;
        shadow_mem[32'h040 >> 2] = 32'h1357_9bdf;
        run_access(dcache_pkg::op_load, 1'b0, 32'h040, '0, 4'h0, 0);   // stale word
        run_access(dcache_pkg::op_load, 1'b1, 32'h040, '0, 4'h0, 0);
        run_access(dcache_pkg::op_load, 1'b0, 32'h040, '0, 4'h0, 0);

        // invalidate forces a fresh line
        run_access(dcache_pkg::op_inval, 1'b0, 32'h040, '0, 4'h0, 0);
        run_access(dcache_pkg::op_load, 1'b0, 32'h040, '0, 4'h0, 1);

        // random mix over 4 tags x 4 sets x 4 words
        for (int i = 0; i < 300; i++) begin
            r     = $random(seed);
            wdata = $random(seed);
            addr  = {22'd0, r[9:8], 2'b00, r[13:12], r[11:10], 2'b00};
            if (r[3:0] < 4'd8) begin
                op = dcache_pkg::op_load;
            end else if (r[3:0] < 4'd14) begin
                op = dcache_pkg::op_store;
            end else begin
                op = dcache_pkg::op_inval;
            end
            unc = (r[7:5] == 3'd0) && (op != dcache_pkg::op_inval);
            run_access(op, unc, addr, wdata, r[19:16], -1);
        end

        @(negedge clk);
        if (req_ready && !mem_req) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("cache did not return to idle after the last request");
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  dcache_pkg::dc_req_t      req,
    output dcache_pkg::dc_resp_t     resp,
    output logic                     mem_req,
    output dcache_pkg::dc_mem_req_t  mem_cmd,
    input  logic                     mem_addr_ok,
    input  logic                     mem_data_ok,
    input  dcache_pkg::dc_line_t     mem_rdata
);

    dcache_pkg::dc_req_t     req_q;
    logic [`DC_TAG_W-1:0]    tag;
    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_OFFSET_W-1:0] word;
    logic [`DC_INDEX_W-1:0]  rd_index;
    logic                    buf_load;
    logic [`DC_WAYS-1:0]     hit, tag_we, inval, line_we, word_we;
    logic                    mem_start, mem_done, line_fill;
    logic                    sel_refill, sel_way, resp_valid;
    dcache_pkg::dc_line_t    line0, line1, fill_line, hit_line;
    logic [31:0]             refill_word;

    // arrays look up the incoming index in the accept cycle
    assign rd_index  = req.paddr[`DC_INDEX_LSB +: `DC_INDEX_W];
    assign line_fill = (req_q.op == dcache_pkg::op_load) && !req_q.uncached;

    dcache_req_buffer u_req_buffer (
        .clk(clk), .rstn(rstn), .load(buf_load), .req_in(req),
        .req_q(req_q), .tag(tag), .index(index), .word(word)
    );

    dcache_tagv u_tagv (
        .clk(clk), .rstn(rstn), .rd_index(rd_index), .cmp_tag(tag), .hit(hit),
        .wr_index(index), .wr_tag(tag), .tag_we(tag_we), .inval(inval)
    );

    dcache_data u_data (
        .clk(clk), .rd_index(rd_index), .line0(line0), .line1(line1),
        .wr_index(index), .wr_word(word), .fill_line(fill_line),
        .wdata(req_q.wdata), .wstrb(req_q.wstrb), .line_we(line_we), .word_we(word_we)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_ready(req_ready),
        .req_q(req_q), .index(index), .hit(hit), .buf_load(buf_load),
        .tag_we(tag_we), .inval(inval), .line_we(line_we), .word_we(word_we),
        .mem_start(mem_start), .mem_done(mem_done), .sel_refill(sel_refill),
        .sel_way(sel_way), .resp_valid(resp_valid)
    );

    dcache_mem_port u_mem_port (
        .clk(clk), .rstn(rstn), .start(mem_start), .req_q(req_q), .word(word),
        .line_fill(line_fill), .mem_req(mem_req), .mem_cmd(mem_cmd),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata),
        .done(mem_done), .fill_line(fill_line), .refill_word(refill_word)
    );

    // response word: hit way from the arrays, or the word the memory returned
    assign hit_line = sel_way ? line1 : line0;

    always_comb begin
        resp.valid = resp_valid;
        resp.rdata = sel_refill ? refill_word : hit_line[word];
    end

endmodule

/* dcache_mem_port.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_mem_port (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  dcache_pkg::dc_req_t      req_q,
    input  logic [`DC_OFFSET_W-1:0]  word,
    input  logic                     line_fill,
    output logic                     mem_req,
    output dcache_pkg::dc_mem_req_t  mem_cmd,
    input  logic                     mem_addr_ok,
    input  logic                     mem_data_ok,
    input  dcache_pkg::dc_line_t     mem_rdata,
    output logic                     done,
    output dcache_pkg::dc_line_t     fill_line,
    output logic [31:0]              refill_word
);

    logic                 pending_q;    // request raised, address not taken yet
    logic                 wait_q;       // address taken, waiting for data
    logic                 take_data;
    dcache_pkg::dc_line_t line_q;

    assign mem_req   = start | pending_q;
    assign take_data = wait_q & mem_data_ok;

    // command comes straight from the held request, stable while mem_req is up
    always_comb begin
        mem_cmd.wr    = (req_q.op == dcache_pkg::op_store);
        mem_cmd.line  = line_fill;
        mem_cmd.addr  = line_fill ? {req_q.paddr[31:`DC_INDEX_LSB], `DC_INDEX_LSB'(0)}
                                  : req_q.paddr;
        mem_cmd.wdata = req_q.wdata;
        mem_cmd.wstrb = req_q.wstrb;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pending_q <= 1'b0;
            wait_q    <= 1'b0;
            done      <= 1'b0;
        end else begin
            pending_q <= mem_req & ~mem_addr_ok;
            if (mem_req && mem_addr_ok) begin
                wait_q <= 1'b1;
            end else if (mem_data_ok) begin
                wait_q <= 1'b0;
            end
            done <= take_data;      // one cycle after data_ok
        end
    end

    always_ff @(posedge clk) begin
        if (take_data) begin
            line_q <= mem_rdata;
        end
    end

    assign fill_line   = line_q;
    assign refill_word = line_fill ? line_q[word] : line_q[0];  // single words come in lane 0

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  dcache_pkg::dc_req_t    req_q,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic [`DC_WAYS-1:0]    hit,
    output logic                   buf_load,
    output logic [`DC_WAYS-1:0]    tag_we,
    output logic [`DC_WAYS-1:0]    inval,
    output logic [`DC_WAYS-1:0]    line_we,
    output logic [`DC_WAYS-1:0]    word_we,
    output logic                   mem_start,
    input  logic                   mem_done,
    output logic                   sel_refill,
    output logic                   sel_way,
    output logic                   resp_valid
);

    dcache_pkg::dc_state_e state_q;
    dcache_pkg::dc_state_e state_d;

    logic [`DC_SETS-1:0] lru_q;     // way used most recently, per set
    logic                victim;
    logic [`DC_WAYS-1:0] victim_oh;
    logic                any_hit;

    // An invalidate marks the other way as most recent, so the not-recent way
    // is always an invalid one whenever the set holds one.
    assign victim    = ~lru_q[index];
    assign victim_oh = `DC_WAYS'(1) << victim;
    assign any_hit   = |hit;

    //////////////////////////////
    // next state and outputs
    //////////////////////////////

    always_comb begin
        state_d    = state_q;
        req_ready  = 1'b0;
        buf_load   = 1'b0;
        tag_we     = '0;
        inval      = '0;
        line_we    = '0;
        word_we    = '0;
        mem_start  = 1'b0;
        sel_refill = 1'b0;
        sel_way    = 1'b0;
        resp_valid = 1'b0;
        case (state_q)
            dcache_pkg::st_idle: begin
                req_ready = 1'b1;
                buf_load  = req_valid;
                if (req_valid) begin
                    state_d = dcache_pkg::st_lookup;
                end
            end
            dcache_pkg::st_lookup: begin
                if (req_q.op == dcache_pkg::op_inval) begin
                    inval      = hit;               // only the hitting way
                    resp_valid = 1'b1;
                    state_d    = dcache_pkg::st_idle;
                end else if (req_q.uncached) begin
                    state_d = dcache_pkg::st_unc_req;   // arrays bypassed
                end else if (req_q.op == dcache_pkg::op_store) begin
                    word_we = hit;                  // no allocate on a miss
                    state_d = dcache_pkg::st_wt_req;
                end else if (any_hit) begin
                    sel_way    = hit[1];
                    resp_valid = 1'b1;
                    state_d    = dcache_pkg::st_idle;
                end else begin
                    state_d = dcache_pkg::st_miss_req;
                end
            end
            dcache_pkg::st_miss_req: begin
                mem_start = 1'b1;
                state_d   = dcache_pkg::st_miss_wait;
            end
            dcache_pkg::st_miss_wait: begin
                if (mem_done) begin
                    line_we    = victim_oh;
                    tag_we     = victim_oh;
                    sel_refill = 1'b1;
                    resp_valid = 1'b1;
                    state_d    = dcache_pkg::st_idle;
                end
            end
            dcache_pkg::st_wt_req: begin
                mem_start = 1'b1;
                state_d   = dcache_pkg::st_wt_wait;
            end
            dcache_pkg::st_wt_wait: begin
                if (mem_done) begin
                    resp_valid = 1'b1;
                    state_d    = dcache_pkg::st_idle;
                end
            end
            dcache_pkg::st_unc_req: begin
                mem_start = 1'b1;
                state_d   = dcache_pkg::st_unc_wait;
            end
            dcache_pkg::st_unc_wait: begin
                if (mem_done) begin
                    sel_refill = 1'b1;              // word from the memory port
                    resp_valid = 1'b1;
                    state_d    = dcache_pkg::st_idle;
                end
            end
            default: state_d = dcache_pkg::st_idle;
        endcase
    end

    //////////////////////////////
    // state and LRU registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= dcache_pkg::st_idle;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == dcache_pkg::st_lookup && any_hit) begin
                if (req_q.op == dcache_pkg::op_inval) begin
                    lru_q[index] <= ~hit[1];        // freed way becomes victim
                end else if (req_q.op == dcache_pkg::op_load && !req_q.uncached) begin
                    lru_q[index] <= hit[1];
                end
            end else if (state_q == dcache_pkg::st_miss_wait && mem_done) begin
                lru_q[index] <= victim;             // refilled way
            end
        end
    end

endmodule

/* dcache_data.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_data (
    input  logic                     clk,
    input  logic [`DC_INDEX_W-1:0]   rd_index,
    output dcache_pkg::dc_line_t     line0,
    output dcache_pkg::dc_line_t     line1,
    input  logic [`DC_INDEX_W-1:0]   wr_index,
    input  logic [`DC_OFFSET_W-1:0]  wr_word,
    input  dcache_pkg::dc_line_t     fill_line,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic [`DC_WAYS-1:0]      line_we,
    input  logic [`DC_WAYS-1:0]      word_we
);

    dcache_pkg::dc_line_t data_mem [`DC_WAYS][`DC_SETS];
    dcache_pkg::dc_line_t line_rd  [`DC_WAYS];

    //////////////////////////////
    // write side
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (line_we[w]) begin
                data_mem[w][wr_index] <= fill_line;     // refill, whole line
            end else if (word_we[w]) begin
                // store hit, merge strobed bytes only
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        data_mem[w][wr_index][wr_word][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    //////////////////////////////
    // read side
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            line_rd[w] <= data_mem[w][rd_index];
        end
    end

    assign line0 = line_rd[0];
    assign line1 = line_rd[1];

endmodule

/* dcache_tagv.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_tagv (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`DC_INDEX_W-1:0] rd_index,
    input  logic [`DC_TAG_W-1:0]   cmp_tag,
    output logic [`DC_WAYS-1:0]    hit,
    input  logic [`DC_INDEX_W-1:0] wr_index,
    input  logic [`DC_TAG_W-1:0]   wr_tag,
    input  logic [`DC_WAYS-1:0]    tag_we,
    input  logic [`DC_WAYS-1:0]    inval
);

    logic [`DC_TAG_W-1:0] tag_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_SETS-1:0]  valid_q [`DC_WAYS];     // one bit per set, per way
    logic [`DC_TAG_W-1:0] tag_rd  [`DC_WAYS];
    logic [`DC_WAYS-1:0]  valid_rd;

    //////////////////////////////
    // tag store
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            tag_rd[w] <= tag_mem[w][rd_index];  // sync read
        end
    end

    //////////////////////////////
    // valid bits
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            valid_rd <= '0;
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (tag_we[w]) begin
                    valid_q[w][wr_index] <= 1'b1;   // refill installs the line
                end else if (inval[w]) begin
                    valid_q[w][wr_index] <= 1'b0;
                end
                valid_rd[w] <= valid_q[w][rd_index];
            end
        end
    end

    // compare against the buffered tag in st_lookup
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit[w] = valid_rd[w] && (tag_rd[w] == cmp_tag);
        end
    end

endmodule

/* dcache_req_buffer.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_req_buffer (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    load,
    input  dcache_pkg::dc_req_t     req_in,
    output dcache_pkg::dc_req_t     req_q,
    output logic [`DC_TAG_W-1:0]    tag,
    output logic [`DC_INDEX_W-1:0]  index,
    output logic [`DC_OFFSET_W-1:0] word
);

    logic held;     // a request has been captured since reset

    //////////////////////////////
    // request register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= req_in;    // kept until the next accept
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            held <= 1'b0;
        end else if (load) begin
            held <= 1'b1;
        end
    end

    //////////////////////////////
    // address split
    //////////////////////////////

    // fields read as zero until the first request lands
    always_comb begin
        tag   = '0;
        index = '0;
        word  = '0;
        if (held) begin
            tag   = req_q.paddr[`DC_TAG_LSB +: `DC_TAG_W];
            index = req_q.paddr[`DC_INDEX_LSB +: `DC_INDEX_W];
            word  = req_q.paddr[`DC_WORD_LSB +: `DC_OFFSET_W];
        end
    end

endmodule

/* dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

    // pipeline request kinds
    typedef enum logic [1:0] {
        op_load  = 2'd0,
        op_store = 2'd1,
        op_inval = 2'd2
    } dc_op_e;

    // controller states
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_lookup    = 3'd1,
        st_miss_req  = 3'd2,
        st_miss_wait = 3'd3,
        st_wt_req    = 3'd4,
        st_wt_wait   = 3'd5,
        st_unc_req   = 3'd6,
        st_unc_wait  = 3'd7
    } dc_state_e;

    // one cache line, word 0 in the low lanes
    typedef logic [`DC_WORDS-1:0][31:0] dc_line_t;

    typedef struct packed {
        dc_op_e      op;
        logic        uncached;
        logic [31:0] paddr;     // physical address
        logic [31:0] wdata;     // store data, bytes in their own lanes
        logic [3:0]  wstrb;
    } dc_req_t;

    typedef struct packed {
        logic        wr;        // 1 for write-through / uncached store
        logic        line;      // whole line read on a cached miss
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } dc_mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } dc_resp_t;

endpackage

/* dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
`define DC_INDEX_W  4                       // set index bits
`define DC_OFFSET_W 2                       // word-in-line bits
`define DC_WAYS     2                       // one LRU bit per set, so 2 only

// derived sizes
`define DC_SETS     (1 << `DC_INDEX_W)
`define DC_WORDS    (1 << `DC_OFFSET_W)
`define DC_TAG_W    (32 - `DC_INDEX_W - `DC_OFFSET_W - 2)

// address field positions, byte offset sits in [1:0]
`define DC_WORD_LSB  2
`define DC_INDEX_LSB (`DC_OFFSET_W + 2)
`define DC_TAG_LSB   (`DC_INDEX_W + `DC_OFFSET_W + 2)

`endif
